// File: Makefile
# Verilator flow for the camera front end

VERILATOR ?= verilator
TOP       ?= camera_pipe_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(wildcard design/*.sv bench/*.sv include/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Regression failed" $(LOG); then \
	  echo "Simulation reported failure, see $(LOG)"; exit 1; \
	elif ! grep -q "Regression passed" $(LOG); then \
	  echo "Simulation ended without a verdict, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/camera_pipe_assertions.sv
// ==============================
// Camera top bound checks
// APB handshake and output stream
// ==============================
`timescale 1ns/1ps
`default_nettype none

module camera_pipe_assertions (
  input logic ccd_pixel_clk,
  input logic reset,
  input logic psel,
  input logic penable,
  input logic pready,
  input logic pslverr,
  input logic pixel_valid
);

  // No wait states
  pready_high: assert property (@(posedge ccd_pixel_clk) pready)
    else $error("pready dropped low");

  // Quiet stream during reset
  valid_in_reset: assert property (@(posedge ccd_pixel_clk) reset |=> !pixel_valid)
    else $error("pixel_valid high while in reset");

  // Still quiet one cycle after release
  valid_after_reset: assert property (@(posedge ccd_pixel_clk) $fell(reset) |=> !pixel_valid)
    else $error("pixel_valid high right after reset release");

  // Slave error only in the access phase
  slverr_in_access: assert property (@(posedge ccd_pixel_clk) pslverr |-> (psel && penable))
    else $error("pslverr outside an APB access cycle");

endmodule

bind camera_pipe_top camera_pipe_assertions u_checks (
  .ccd_pixel_clk, .reset, .psel, .penable, .pready, .pslverr, .pixel_valid
);

`default_nettype wire

// File: bench/camera_pipe_tb.sv
// ==============================
// Camera front end testbench
// APB setup, random Bayer frames, model compare
// ==============================
`timescale 1ns/1ps
`default_nettype none

`include "cam_consts.svh"

module camera_pipe_tb
  import cam_pkg::*;
();

  logic          ccd_pixel_clk;
  logic          reset;
  logic          psel, penable, pwrite;
  apb_addr_t     paddr;
  apb_word_t     pwdata;
  raw_pixel_t    raw_data;
  logic          frame_valid, line_valid;
  apb_word_t     prdata;
  logic          pready, pslverr;
  packed_pixel_t pixel_data;
  logic          pixel_valid, frame_active;

  logic [15:0] exp_q[$];        // Expected words, oldest first
  logic [15:0] exp_word;
  int          value_errors, other_errors;
  int          ones_seen, zeros_seen;
  int          frames_done;     // Frames the DUT should have captured
  logic [31:0] sh_ctrl, sh_width, sh_height, sh_hue, sh_level;   // Register shadows
  int          pix [0:9][0:19];   // Current raw frame

  camera_pipe_top uut (.*);

  initial begin
    ccd_pixel_clk = 1'b0;
    forever #2 ccd_pixel_clk = ~ccd_pixel_clk;
  end

  // ============================== APB
  task automatic apb_xfer(input logic wr, input apb_addr_t addr, input apb_word_t wdata,
                          output apb_word_t rdata, output logic err);
    int waited;
    waited = 0;
    @(negedge ccd_pixel_clk);
    psel    = 1'b1;   // Setup phase
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge ccd_pixel_clk);
    penable = 1'b1;   // Access phase
    #1;
    while (!pready && waited < 20) begin
      @(negedge ccd_pixel_clk);
      #1;
      waited++;
    end
    if (!pready) begin
      other_errors++;
      $display("APB access to 0x%02h never completed, pready stayed low", addr);
    end
    rdata = prdata;
    err   = pslverr;
    @(negedge ccd_pixel_clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic write_reg(input apb_addr_t addr, input apb_word_t data, input logic exp_err);
    apb_word_t rdata;
    logic      err;
    apb_xfer(1'b1, addr, data, rdata, err);
    assert (err == exp_err) else begin
      value_errors++;
      $display("Error: pslverr on write 0x%02h got 0x%0h expected 0x%0h", addr, err, exp_err);
    end
  endtask

  task automatic read_check(input apb_addr_t addr, input apb_word_t exp, input logic exp_err);
    apb_word_t rdata;
    logic      err;
    apb_xfer(1'b0, addr, '0, rdata, err);
    assert (err == exp_err) else begin
      value_errors++;
      $display("Error: pslverr on read 0x%02h got 0x%0h expected 0x%0h", addr, err, exp_err);
    end
    if (!exp_err) begin
      assert (rdata == exp) else begin
        value_errors++;
        $display("Error: prdata at 0x%02h got 0x%08h expected 0x%08h", addr, rdata, exp);
      end
    end
  endtask

  // Write and track the masked value
  task automatic set_reg(input apb_addr_t addr, input apb_word_t data);
    write_reg(addr, data, 1'b0);
    case (addr)
      `CAM_REG_CTRL:   sh_ctrl   = data & 32'h3;
      `CAM_REG_WIDTH:  sh_width  = data & 32'hFFF;
      `CAM_REG_HEIGHT: sh_height = data & 32'hFFF;
      `CAM_REG_HUE:    sh_hue    = data & 32'hFFFF;
      default:         sh_level  = data & 32'hFFFF;
    endcase
  endtask

  task automatic check_regs();
    read_check(`CAM_REG_CTRL, sh_ctrl, 1'b0);
    read_check(`CAM_REG_WIDTH, sh_width, 1'b0);
    read_check(`CAM_REG_HEIGHT, sh_height, 1'b0);
    read_check(`CAM_REG_HUE, sh_hue, 1'b0);
    read_check(`CAM_REG_LEVEL, sh_level, 1'b0);
    read_check(`CAM_REG_FRAMES, frames_done, 1'b0);
  endtask

  // Capture flag against the expected FSM state
  task automatic check_frame_active(input bit exp_active);
    assert (frame_active == exp_active) else begin
      value_errors++;
      $display("Error: frame_active got 0x%0h expected 0x%0h", frame_active, exp_active);
    end
  endtask

  // ============================== Reference model
  function automatic logic [15:0] model_word(int r, int g, int b);
    int r8, g8, b8, mx, mn, h;
    r8 = r >> 4;   // Top eight bits
    g8 = g >> 4;
    b8 = b >> 4;
    if (sh_ctrl[1])
      return 16'(((r >> 7) << 10) | ((g >> 7) << 5) | (b >> 7));   // RGB555
    mx = r8;
    if (g8 > mx) mx = g8;
    if (b8 > mx) mx = b8;
    mn = r8;
    if (g8 < mn) mn = g8;
    if (b8 < mn) mn = b8;
    if (mx == mn) h = 0;   // Grey
    else if (r8 == mx) h = (43 * (g8 - b8)) / (mx - mn);
    else if (g8 == mx) h = 85 + (43 * (b8 - r8)) / (mx - mn);
    else h = 171 + (43 * (r8 - g8)) / (mx - mn);
    h = h & 255;
    if (h >= int'(sh_hue[7:0]) && h <= int'(sh_hue[15:8]) &&
        (mx - mn) >= int'(sh_level[7:0]) && mx >= int'(sh_level[15:8]))
      return 16'h00FF;
    return 16'h0000;
  endfunction

  // ============================== Sensor
  task automatic send_frame(input int cols, input int rows, input bit expect_out);
    int w, h, x, y, r, g, b;
    w = (cols < sh_width) ? cols : sh_width;    // Crop window
    h = (rows < sh_height) ? rows : sh_height;
    for (y = 0; y < rows; y++)
      for (x = 0; x < cols; x++)
        pix[y][x] = $urandom & 32'hFFF;
    if (expect_out) begin
      for (y = 0; y < h / 2; y++) begin
        for (x = 0; x < w / 2; x++) begin
          r = pix[2*y][2*x+1];                               // R, upper right
          g = (pix[2*y][2*x] + pix[2*y+1][2*x+1]) >> 1;      // Both greens
          b = pix[2*y+1][2*x];                               // B, lower left
          exp_q.push_back(model_word(r, g, b));
        end
      end
      frames_done++;
    end
    @(negedge ccd_pixel_clk);
    frame_valid = 1'b1;
    repeat (3) @(negedge ccd_pixel_clk);   // Front porch
    check_frame_active(expect_out);
    for (y = 0; y < rows; y++) begin
      for (x = 0; x < cols; x++) begin
        line_valid = 1'b1;
        raw_data   = raw_pixel_t'(pix[y][x]);
        @(negedge ccd_pixel_clk);
      end
      line_valid = 1'b0;
      repeat (2 + $urandom % 4) @(negedge ccd_pixel_clk);   // Line blanking
    end
    check_frame_active(expect_out);
    frame_valid = 1'b0;
    repeat (10) @(negedge ccd_pixel_clk);   // Frame blanking
    check_frame_active(1'b0);
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < 100) begin
      @(negedge ccd_pixel_clk);
      waited++;
    end
    if (exp_q.size() != 0) begin
      other_errors++;
      $display("Timed out with %0d expected pixels never delivered", exp_q.size());
      exp_q.delete();
    end
  endtask

  // ============================== Output monitor
  always @(negedge ccd_pixel_clk) begin
    if (!reset && pixel_valid) begin
      assert (exp_q.size() != 0) else begin
        other_errors++;
        $display("pixel_valid rose with no pixel pending in the model");
      end
      if (exp_q.size() != 0) begin
        exp_word = exp_q.pop_front();
        assert (pixel_data == exp_word) else begin
          value_errors++;
          $display("Error: pixel_data got 0x%04h expected 0x%04h", pixel_data, exp_word);
        end
        if (pixel_data == 16'h00FF) ones_seen++;
        if (pixel_data == 16'h0000) zeros_seen++;
      end
    end
  end

  // ============================== Sequence
  initial begin
    void'($urandom(32'h7220_86c9));
    reset       = 1'b1;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pwdata      = '0;
    raw_data    = '0;
    frame_valid = 1'b0;
    line_valid  = 1'b0;
    {value_errors, other_errors, ones_seen, zeros_seen, frames_done} = '0;
    sh_ctrl   = 32'h0;
    sh_width  = 32'd640;
    sh_height = 32'd480;
    sh_hue    = 32'h1400;
    sh_level  = 32'h0;
    repeat (16) @(negedge ccd_pixel_clk);
    reset = 1'b0;

    // Reset values, random readback, bad accesses
    check_regs();
    repeat (4) begin
      set_reg(`CAM_REG_WIDTH, $urandom);
      set_reg(`CAM_REG_HEIGHT, $urandom);
      set_reg(`CAM_REG_HUE, $urandom);
      set_reg(`CAM_REG_LEVEL, $urandom);
      check_regs();
    end
    write_reg(8'h18, $urandom, 1'b1);
    write_reg(8'h40, $urandom, 1'b1);
    write_reg(8'h02, $urandom, 1'b1);            // Misaligned
    write_reg(`CAM_REG_FRAMES, $urandom, 1'b1);  // Read only
    read_check(8'hFC, '0, 1'b1);
    check_regs();

    // Start low, then start in mid frame
    set_reg(`CAM_REG_WIDTH, 16);
    set_reg(`CAM_REG_HEIGHT, 8);
    set_reg(`CAM_REG_CTRL, 32'h2);
    send_frame(16, 8, 1'b0);
    read_check(`CAM_REG_FRAMES, frames_done, 1'b0);
    fork
      send_frame(16, 8, 1'b0);
      begin
        repeat (20) @(negedge ccd_pixel_clk);
        set_reg(`CAM_REG_CTRL, 32'h3);
      end
    join

    // RGB555 frames
    repeat (2) begin
      send_frame(16, 8, 1'b1);
      wait_drain();
    end

    // Binary image, random thresholds
    set_reg(`CAM_REG_CTRL, 32'h1);
    set_reg(`CAM_REG_HUE, $urandom);
    set_reg(`CAM_REG_LEVEL, $urandom);
    repeat (2) begin
      send_frame(16, 8, 1'b1);
      wait_drain();
    end

    // Narrow hue window, no level limits
    set_reg(`CAM_REG_HUE, 32'h6020);
    set_reg(`CAM_REG_LEVEL, 32'h0);
    ones_seen  = 0;
    zeros_seen = 0;
    repeat (2) begin
      send_frame(16, 8, 1'b1);
      wait_drain();
    end
    assert (ones_seen > 0 && zeros_seen > 0) else begin
      other_errors++;
      $display("Narrow hue window gave %0d set and %0d clear pixels, not a mix",
               ones_seen, zeros_seen);
    end

    // Oversized frames cropped to 16 x 8
    set_reg(`CAM_REG_CTRL, 32'h3);
    repeat (2) begin
      send_frame(20, 10, 1'b1);
      wait_drain();
    end
    set_reg(`CAM_REG_CTRL, 32'h0);
    check_regs();   // FRAMES equals captured count

    $display("Checks done: %0d value errors, %0d other errors", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: design/bayer_to_rgb.sv
// ==============================
// Bayer demosaic
// One RGB pixel per 2x2 block
// ==============================
`timescale 1ns/1ps
`default_nettype none

`include "cam_consts.svh"

module bayer_to_rgb
  import cam_pkg::*;
(
  input  logic       ccd_pixel_clk,
  input  logic       reset,
  input  raw_pixel_t cap_data,
  input  logic       cap_valid,
  input  coord_t     cap_x,
  input  coord_t     cap_y,
  output colour_t    red,
  output colour_t    green,
  output colour_t    blue,
  output logic       rgb_valid
);

  // Even row kept as {R, G} pairs, one entry per two columns
  localparam int PAIR_AW = $clog2(`CAM_MAX_WIDTH) - 1;

  logic [2*`CAM_RAW_W-1:0] line_buf [`CAM_MAX_WIDTH/2];
  logic [PAIR_AW-1:0]      pair_addr;
  raw_pixel_t              prev_q;      // Previous sample, current row
  raw_pixel_t              buf_red;     // Upper row, same column
  raw_pixel_t              buf_green;   // Upper row, previous column
  logic [`CAM_RAW_W:0]     green_sum;   // One extra bit for the carry
  logic                    even_row;
  logic                    odd_col;
  logic                    block_done;

  assign pair_addr  = cap_x[PAIR_AW:1];
  assign even_row   = !cap_y[0];
  assign odd_col    = cap_x[0];
  assign block_done = cap_valid && !even_row && odd_col;   // Lower right G

  assign {buf_red, buf_green} = line_buf[pair_addr];
  assign green_sum = {1'b0, buf_green} + {1'b0, cap_data};

  // ============================== Line buffer
  always_ff @(posedge ccd_pixel_clk) begin
    if (cap_valid)
      prev_q <= cap_data;
    if (cap_valid && even_row && odd_col)
      line_buf[pair_addr] <= {cap_data, prev_q};   // R at odd col, G before it
  end

  // ============================== RGB out
  always_ff @(posedge ccd_pixel_clk) begin
    if (block_done) begin
      red   <= buf_red;
      green <= green_sum[`CAM_RAW_W:1];   // Mean of both greens
      blue  <= prev_q;                    // B just left of this G
    end
  end

  always_ff @(posedge ccd_pixel_clk) begin
    if (reset)
      rgb_valid <= 1'b0;
    else
      rgb_valid <= block_done;
  end

endmodule

`default_nettype wire

// File: design/cam_pkg.sv
// ==============================
// Camera front end types
// ==============================
`default_nettype none

`include "cam_consts.svh"

package cam_pkg;

  // Sample and pixel widths
  typedef logic [`CAM_RAW_W-1:0]       raw_pixel_t;    // One Bayer sample
  typedef logic [`CAM_RAW_W-1:0]       colour_t;       // Demosaiced component
  typedef logic [7:0]                  level_t;        // Hue, threshold, short component
  typedef logic [`CAM_COORD_W-1:0]     coord_t;        // Column, row or size
  typedef logic [31:0]                 frame_count_t;
  typedef logic [15:0]                 packed_pixel_t; // Output stream word

  // APB
  typedef logic [`CAM_APB_ADDR_W-1:0]  apb_addr_t;
  typedef logic [31:0]                 apb_word_t;

  // Capture control FSM
  typedef enum logic [1:0] {
    cap_idle,
    cap_wait_frame,
    cap_capturing
  } cap_state_t;

endpackage

`default_nettype wire

// File: design/cam_regs_apb.sv
// ==============================
// APB register block
// Capture and threshold settings, frame count readback
// ==============================
`timescale 1ns/1ps
`default_nettype none

`include "cam_consts.svh"

module cam_regs_apb
  import cam_pkg::*;
(
  input  logic         ccd_pixel_clk,
  input  logic         reset,
  input  logic         psel,
  input  logic         penable,
  input  logic         pwrite,
  input  apb_addr_t    paddr,
  input  apb_word_t    pwdata,
  input  frame_count_t frame_count,
  output apb_word_t    prdata,
  output logic         pready,
  output logic         pslverr,
  output logic         start,
  output logic         rgb_mode,
  output coord_t       img_width,
  output coord_t       img_height,
  output level_t       hue_low,
  output level_t       hue_high,
  output level_t       sat_min,
  output level_t       bri_min
);

  logic      access;     // Second APB phase
  logic      addr_hit;   // Mapped offset
  logic      ro_write;   // Write to FRAMES
  logic      wr_en;
  apb_word_t rd_word;

  assign access   = psel && penable;
  assign ro_write = pwrite && (paddr == `CAM_REG_FRAMES);
  assign wr_en    = access && pwrite && !pslverr;

  // ============================== Decode
  always_comb begin
    addr_hit = 1'b1;
    rd_word  = '0;
    case (paddr)
      `CAM_REG_CTRL:   rd_word = {30'd0, rgb_mode, start};
      `CAM_REG_WIDTH:  rd_word = {{(32-`CAM_COORD_W){1'b0}}, img_width};
      `CAM_REG_HEIGHT: rd_word = {{(32-`CAM_COORD_W){1'b0}}, img_height};
      `CAM_REG_HUE:    rd_word = {16'd0, hue_high, hue_low};
      `CAM_REG_LEVEL:  rd_word = {16'd0, bri_min, sat_min};
      `CAM_REG_FRAMES: rd_word = frame_count;
      default:         addr_hit = 1'b0;
    endcase
  end

  assign pready  = 1'b1;                                // No wait states
  assign pslverr = access && (!addr_hit || ro_write);   // Bad offset or RO write
  assign prdata  = (psel && !pwrite) ? rd_word : '0;

  // ============================== Settings
  always_ff @(posedge ccd_pixel_clk) begin
    if (reset) begin
      {rgb_mode, start}  <= `CAM_RST_CTRL;
      img_width          <= `CAM_RST_WIDTH;
      img_height         <= `CAM_RST_HEIGHT;
      {hue_high, hue_low} <= `CAM_RST_HUE;
      {bri_min, sat_min} <= `CAM_RST_LEVEL;
    end else if (wr_en) begin
      case (paddr)
        `CAM_REG_CTRL:   {rgb_mode, start}   <= pwdata[1:0];
        `CAM_REG_WIDTH:  img_width           <= pwdata[`CAM_COORD_W-1:0];
        `CAM_REG_HEIGHT: img_height          <= pwdata[`CAM_COORD_W-1:0];
        `CAM_REG_HUE:    {hue_high, hue_low} <= pwdata[15:0];
        `CAM_REG_LEVEL:  {bri_min, sat_min}  <= pwdata[15:0];
        default: ;                            // FRAMES is read only
      endcase
    end
  end

endmodule

`default_nettype wire

// File: design/camera_pipe_top.sv
// ==============================
// Camera front end top
// APB registers around the capture datapath
// ==============================
`timescale 1ns/1ps
`default_nettype none

module camera_pipe_top
  import cam_pkg::*;
(
  input  logic          ccd_pixel_clk,
  input  logic          reset,
  input  logic          psel,
  input  logic          penable,
  input  logic          pwrite,
  input  apb_addr_t     paddr,
  input  apb_word_t     pwdata,
  input  raw_pixel_t    raw_data,
  input  logic          frame_valid,
  input  logic          line_valid,
  output apb_word_t     prdata,
  output logic          pready,
  output logic          pslverr,
  output packed_pixel_t pixel_data,
  output logic          pixel_valid,
  output logic          frame_active
);

  // Settings
  logic         start, rgb_mode;
  coord_t       img_width, img_height;
  level_t       hue_low, hue_high, sat_min, bri_min;
  frame_count_t frame_count;
  // Capture stream
  raw_pixel_t   cap_data;
  logic         cap_valid;
  coord_t       cap_x, cap_y;
  // Demosaic and binary stream
  colour_t      red, green, blue;
  logic         rgb_valid;
  logic         bin_pixel, bin_valid;

  cam_regs_apb u_regs (
    .ccd_pixel_clk, .reset, .psel, .penable, .pwrite, .paddr, .pwdata, .frame_count,
    .prdata, .pready, .pslverr, .start, .rgb_mode, .img_width, .img_height,
    .hue_low, .hue_high, .sat_min, .bri_min
  );

  frame_capture u_capture (
    .ccd_pixel_clk, .reset, .raw_data, .frame_valid, .line_valid, .start,
    .img_width, .img_height, .cap_data, .cap_valid, .cap_x, .cap_y,
    .frame_active, .frame_count
  );

  bayer_to_rgb u_bayer (
    .ccd_pixel_clk, .reset, .cap_data, .cap_valid, .cap_x, .cap_y,
    .red, .green, .blue, .rgb_valid
  );

  hue_threshold u_hue (
    .ccd_pixel_clk, .reset, .red, .green, .blue, .rgb_valid,
    .hue_low, .hue_high, .sat_min, .bri_min,
    .hue(), .bin_pixel, .bin_valid   // Hue stays internal
  );

  pixel_packer u_packer (
    .ccd_pixel_clk, .reset, .red, .green, .blue, .rgb_valid,
    .bin_pixel, .bin_valid, .rgb_mode, .pixel_data, .pixel_valid
  );

endmodule

`default_nettype wire

// File: design/frame_capture.sv
// ==============================
// Sensor capture
// Pin registers, start control, crop, frame count
// ==============================
`timescale 1ns/1ps
`default_nettype none

module frame_capture
  import cam_pkg::*;
(
  input  logic         ccd_pixel_clk,
  input  logic         reset,
  input  raw_pixel_t   raw_data,
  input  logic         frame_valid,
  input  logic         line_valid,
  input  logic         start,
  input  coord_t       img_width,
  input  coord_t       img_height,
  output raw_pixel_t   cap_data,
  output logic         cap_valid,
  output coord_t       cap_x,
  output coord_t       cap_y,
  output logic         frame_active,
  output frame_count_t frame_count
);

  raw_pixel_t raw_q;
  logic       fval_q, lval_q;   // Registered pins
  logic       fval_d, lval_d;   // One more cycle for edges
  cap_state_t state, state_nxt;
  coord_t     x_cnt, y_cnt;
  logic       frame_rise, frame_fall, line_fall;
  logic       capture_on, in_window;

  assign frame_rise = fval_q && !fval_d;
  assign frame_fall = !fval_q && fval_d;
  assign line_fall  = !lval_q && lval_d;

  // Pin and edge registers
  always_ff @(posedge ccd_pixel_clk) begin
    raw_q <= raw_data;
  end

  always_ff @(posedge ccd_pixel_clk) begin
    if (reset) begin
      {fval_q, lval_q, fval_d, lval_d} <= '0;
      state <= cap_idle;
    end else begin
      fval_q <= frame_valid;
      lval_q <= line_valid;
      fval_d <= fval_q;
      lval_d <= lval_q;
      state  <= state_nxt;
    end
  end

  // ============================== Start control FSM
  always_comb begin
    state_nxt = state;
    case (state)
      cap_idle:       if (start) state_nxt = cap_wait_frame;
      cap_wait_frame: if (frame_rise) state_nxt = cap_capturing;
      cap_capturing:  if (frame_fall) state_nxt = start ? cap_wait_frame : cap_idle;
      default:        state_nxt = cap_idle;
    endcase
  end

  // First sample of a frame may arrive with the rising frame_valid
  assign capture_on   = (state == cap_capturing) || (state == cap_wait_frame && frame_rise);
  assign in_window    = (x_cnt < img_width) && (y_cnt < img_height);   // Crop
  assign frame_active = (state == cap_capturing);

  // ============================== Coordinates
  always_ff @(posedge ccd_pixel_clk) begin
    if (reset) begin
      x_cnt       <= '0;
      y_cnt       <= '0;
      cap_valid   <= 1'b0;
      frame_count <= '0;
    end else begin
      x_cnt <= lval_q ? x_cnt + 1'b1 : '0;   // Column within the line
      if (!fval_q) y_cnt <= '0;
      else if (line_fall) y_cnt <= y_cnt + 1'b1;
      cap_valid <= lval_q && capture_on && in_window;
      if (state == cap_capturing && frame_fall)
        frame_count <= frame_count + 1'b1;   // Captured frame done
    end
  end

  always_ff @(posedge ccd_pixel_clk) begin
    cap_data <= raw_q;
    cap_x    <= x_cnt;
    cap_y    <= y_cnt;
  end

endmodule

`default_nettype wire

// File: design/hue_threshold.sv
// ==============================
// Hue and binarization
// Two stages: extremes, then hue and thresholds
// ==============================
`timescale 1ns/1ps
`default_nettype none

`include "cam_consts.svh"

module hue_threshold
  import cam_pkg::*;
(
  input  logic    ccd_pixel_clk,
  input  logic    reset,
  input  colour_t red,
  input  colour_t green,
  input  colour_t blue,
  input  logic    rgb_valid,
  input  level_t  hue_low,
  input  level_t  hue_high,
  input  level_t  sat_min,
  input  level_t  bri_min,
  output level_t  hue,
  output logic    bin_pixel,
  output logic    bin_valid
);

  localparam logic [1:0] CH_RED   = 2'd0;
  localparam logic [1:0] CH_GREEN = 2'd1;
  localparam logic [1:0] CH_BLUE  = 2'd2;

  level_t r8, g8, b8, max_c, min_c;
  logic [1:0] win_c;
  level_t r_q, g_q, b_q, max_q, delta_q;   // Stage 1 registers
  logic [1:0] win_q;
  logic s1_valid;

  logic signed [8:0]  diff;
  logic signed [15:0] scaled, divisor, quot;
  level_t base, hue_c;
  logic   in_hue;

  assign r8 = red[`CAM_RAW_W-1 -: 8];
  assign g8 = green[`CAM_RAW_W-1 -: 8];
  assign b8 = blue[`CAM_RAW_W-1 -: 8];

  // ============================== Stage 1
  always_comb begin
    if (r8 >= g8 && r8 >= b8) begin   // Ties favour red, then green
      win_c = CH_RED;
      max_c = r8;
    end else if (g8 >= b8) begin
      win_c = CH_GREEN;
      max_c = g8;
    end else begin
      win_c = CH_BLUE;
      max_c = b8;
    end
    min_c = r8;
    if (g8 < min_c) min_c = g8;
    if (b8 < min_c) min_c = b8;
  end

  always_ff @(posedge ccd_pixel_clk) begin
    {r_q, g_q, b_q} <= {r8, g8, b8};
    max_q   <= max_c;
    delta_q <= max_c - min_c;
    win_q   <= win_c;
  end

  // ============================== Stage 2
  always_comb begin
    case (win_q)
      CH_GREEN: begin
        base = 8'd85;
        diff = $signed({1'b0, b_q}) - $signed({1'b0, r_q});
      end
      CH_BLUE: begin
        base = 8'd171;
        diff = $signed({1'b0, r_q}) - $signed({1'b0, g_q});
      end
      default: begin
        base = 8'd0;
        diff = $signed({1'b0, g_q}) - $signed({1'b0, b_q});
      end
    endcase
    scaled  = diff * 16'sd43;
    divisor = (delta_q == '0) ? 16'sd1 : $signed({8'd0, delta_q});   // Grey guard
    quot    = scaled / divisor;                 // Truncates toward zero
    hue_c   = (delta_q == '0) ? '0 : base + quot[7:0];   // Wraps mod 256
    in_hue  = (hue_c >= hue_low) && (hue_c <= hue_high);
  end

  always_ff @(posedge ccd_pixel_clk) begin
    hue       <= hue_c;
    bin_pixel <= in_hue && (delta_q >= sat_min) && (max_q >= bri_min);
  end

  always_ff @(posedge ccd_pixel_clk) begin
    if (reset) begin
      s1_valid  <= 1'b0;
      bin_valid <= 1'b0;
    end else begin
      s1_valid  <= rgb_valid;
      bin_valid <= s1_valid;
    end
  end

endmodule

`default_nettype wire

// File: design/pixel_packer.sv
// ==============================
// Output word packer
// RGB555 or 8-bit binary image
// ==============================
`timescale 1ns/1ps
`default_nettype none

`include "cam_consts.svh"

module pixel_packer
  import cam_pkg::*;
(
  input  logic          ccd_pixel_clk,
  input  logic          reset,
  input  colour_t       red,
  input  colour_t       green,
  input  colour_t       blue,
  input  logic          rgb_valid,
  input  logic          bin_pixel,
  input  logic          bin_valid,
  input  logic          rgb_mode,
  output packed_pixel_t pixel_data,
  output logic          pixel_valid
);

  logic [14:0] rgb15_d1, rgb15_d2;   // Top five bits of R, G, B

  // Two cycle delay to meet the hue result
  always_ff @(posedge ccd_pixel_clk) begin
    if (rgb_valid)
      rgb15_d1 <= {red[`CAM_RAW_W-1 -: 5], green[`CAM_RAW_W-1 -: 5], blue[`CAM_RAW_W-1 -: 5]};
    rgb15_d2 <= rgb15_d1;
  end

  always_ff @(posedge ccd_pixel_clk) begin
    if (bin_valid)
      pixel_data <= rgb_mode ? {1'b0, rgb15_d2} : {8'h00, {8{bin_pixel}}};
  end

  always_ff @(posedge ccd_pixel_clk) begin
    if (reset)
      pixel_valid <= 1'b0;
    else
      pixel_valid <= bin_valid;   // Same strobe in both modes
  end

endmodule

`default_nettype wire

// File: include/cam_consts.svh
// ==============================
// Camera front end constants
// Widths, APB map, reset values
// ==============================
`ifndef CAM_CONSTS_SVH
`define CAM_CONSTS_SVH

// Datapath widths
`define CAM_RAW_W        12
`define CAM_COORD_W      12
`define CAM_MAX_WIDTH    1024      // Raw columns held in the line buffer
`define CAM_APB_ADDR_W   8

// ============================== APB register map
`define CAM_REG_CTRL     8'h00     // [0] start, [1] rgb_mode
`define CAM_REG_WIDTH    8'h04
`define CAM_REG_HEIGHT   8'h08
`define CAM_REG_HUE      8'h0C     // [7:0] low, [15:8] high
`define CAM_REG_LEVEL    8'h10     // [7:0] saturation, [15:8] brightness
`define CAM_REG_FRAMES   8'h14     // Read only

// Reset values
`define CAM_RST_CTRL     2'b00
`define CAM_RST_WIDTH    12'd640
`define CAM_RST_HEIGHT   12'd480
`define CAM_RST_HUE      16'h1400  // High 20, low 0
`define CAM_RST_LEVEL    16'h0000

`endif

// File: project.f
+incdir+include
design/cam_pkg.sv
design/cam_regs_apb.sv
design/frame_capture.sv
design/bayer_to_rgb.sv
design/hue_threshold.sv
design/pixel_packer.sv
design/camera_pipe_top.sv
bench/camera_pipe_assertions.sv
bench/camera_pipe_tb.sv
